/* source/rv64_isa_pkg.sv */
// RV64I encoding constants, base widths and reset vector
`default_nettype none

package rv64_isa_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [31:0]     inst_t;

  localparam word_t RESET_PC = 64'h8000_0000;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011,
    OP_REG    = 7'b0110011,
    OP_REG_32 = 7'b0111011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 fields
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_REMW = 3'b110;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_W    = 3'b010;
  localparam logic [2:0] F3_D    = 3'b011;
  localparam logic [2:0] F3_PRIV = 3'b000;

  // funct7 fields
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam logic [11:0] F12_EBREAK = 12'h001;

endpackage

`default_nettype wire

/* source/rv64_ctrl_pkg.sv */
// Internal control encodings shared by decoder and datapath units
`default_nettype none

package rv64_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLTU   = 4'd2,
    ALU_COPY_B = 4'd3,
    ALU_REMW   = 4'd4,
    ALU_NONE   = 4'd15
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JAL  = 3'd1,
    BR_JALR = 3'd2,
    BR_EQ   = 3'd4,
    BR_NE   = 3'd5,
    BR_LTU  = 3'd6,
    BR_GEU  = 3'd7
  } branch_e;

  // Word accesses are sign extended on load
  typedef enum logic [1:0] {
    MEM_NONE   = 2'd0,
    MEM_WORD   = 2'd1,
    MEM_DOUBLE = 2'd2
  } mem_op_e;

  typedef enum logic [0:0] {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_src_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2
  } b_src_e;

endpackage

`default_nettype wire

/* source/rv64_idu.sv */
// Instruction decoder producing register indices, immediate and control
`default_nettype none

module rv64_idu (
  input  wire  rv64_isa_pkg::inst_t     i_inst,
  output rv64_isa_pkg::reg_idx_t        o_rs1,
  output rv64_isa_pkg::reg_idx_t        o_rs2,
  output rv64_isa_pkg::reg_idx_t        o_rd,
  output rv64_isa_pkg::word_t           o_imm,
  output logic                          o_reg_wen,
  output rv64_ctrl_pkg::a_src_e         o_a_src,
  output rv64_ctrl_pkg::b_src_e         o_b_src,
  output rv64_ctrl_pkg::alu_op_e        o_alu_op,
  output logic                          o_word_cut,
  output rv64_ctrl_pkg::branch_e        o_branch,
  output rv64_ctrl_pkg::mem_op_e        o_mem_op,
  output logic                          o_mem_wen,
  output logic                          o_mem_to_reg,
  output logic                          o_halt
);

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_U,
    FMT_S,
    FMT_B,
    FMT_J
  } fmt_e;

  rv64_isa_pkg::opcode_e opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [11:0]           funct12;
  fmt_e                  fmt;

  assign opcode  = rv64_isa_pkg::opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign funct12 = i_inst[31:20];

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

  // Classification; anything unmatched keeps the inert defaults
  always_comb begin
    fmt          = FMT_R;
    o_reg_wen    = 1'b0;
    o_a_src      = rv64_ctrl_pkg::A_RS1;
    o_b_src      = rv64_ctrl_pkg::B_RS2;
    o_alu_op     = rv64_ctrl_pkg::ALU_NONE;
    o_word_cut   = 1'b0;
    o_branch     = rv64_ctrl_pkg::BR_NONE;
    o_mem_op     = rv64_ctrl_pkg::MEM_NONE;
    o_mem_wen    = 1'b0;
    o_mem_to_reg = 1'b0;
    o_halt       = 1'b0;
    case (opcode)
      rv64_isa_pkg::OP_LUI: begin
        fmt       = FMT_U;
        o_reg_wen = 1'b1;
        o_b_src   = rv64_ctrl_pkg::B_IMM;
        o_alu_op  = rv64_ctrl_pkg::ALU_COPY_B;
      end
      rv64_isa_pkg::OP_AUIPC: begin
        fmt       = FMT_U;
        o_reg_wen = 1'b1;
        o_a_src   = rv64_ctrl_pkg::A_PC;
        o_b_src   = rv64_ctrl_pkg::B_IMM;
        o_alu_op  = rv64_ctrl_pkg::ALU_ADD;
      end
      // Jumps link pc + 4 through the ALU
      rv64_isa_pkg::OP_JAL: begin
        fmt       = FMT_J;
        o_reg_wen = 1'b1;
        o_a_src   = rv64_ctrl_pkg::A_PC;
        o_b_src   = rv64_ctrl_pkg::B_FOUR;
        o_alu_op  = rv64_ctrl_pkg::ALU_ADD;
        o_branch  = rv64_ctrl_pkg::BR_JAL;
      end
      rv64_isa_pkg::OP_JALR: begin
        fmt = FMT_I;
        if (funct3 == rv64_isa_pkg::F3_JALR) begin
          o_reg_wen = 1'b1;
          o_a_src   = rv64_ctrl_pkg::A_PC;
          o_b_src   = rv64_ctrl_pkg::B_FOUR;
          o_alu_op  = rv64_ctrl_pkg::ALU_ADD;
          o_branch  = rv64_ctrl_pkg::BR_JALR;
        end
      end
      rv64_isa_pkg::OP_BRANCH: begin
        fmt = FMT_B;
        case (funct3)
          rv64_isa_pkg::F3_BEQ:  o_branch = rv64_ctrl_pkg::BR_EQ;
          rv64_isa_pkg::F3_BNE:  o_branch = rv64_ctrl_pkg::BR_NE;
          rv64_isa_pkg::F3_BLTU: o_branch = rv64_ctrl_pkg::BR_LTU;
          rv64_isa_pkg::F3_BGEU: o_branch = rv64_ctrl_pkg::BR_GEU;
          default:               o_branch = rv64_ctrl_pkg::BR_NONE;
        endcase
      end
      rv64_isa_pkg::OP_LOAD: begin
        fmt = FMT_I;
        if (funct3 == rv64_isa_pkg::F3_W || funct3 == rv64_isa_pkg::F3_D) begin
          o_reg_wen    = 1'b1;
          o_b_src      = rv64_ctrl_pkg::B_IMM;
          o_alu_op     = rv64_ctrl_pkg::ALU_ADD;
          o_mem_to_reg = 1'b1;
          o_mem_op     = (funct3 == rv64_isa_pkg::F3_D) ? rv64_ctrl_pkg::MEM_DOUBLE
                                                        : rv64_ctrl_pkg::MEM_WORD;
        end
      end
      rv64_isa_pkg::OP_STORE: begin
        fmt = FMT_S;
        if (funct3 == rv64_isa_pkg::F3_W || funct3 == rv64_isa_pkg::F3_D) begin
          o_b_src   = rv64_ctrl_pkg::B_IMM;
          o_alu_op  = rv64_ctrl_pkg::ALU_ADD;
          o_mem_wen = 1'b1;
          o_mem_op  = (funct3 == rv64_isa_pkg::F3_D) ? rv64_ctrl_pkg::MEM_DOUBLE
                                                     : rv64_ctrl_pkg::MEM_WORD;
        end
      end
      rv64_isa_pkg::OP_IMM, rv64_isa_pkg::OP_IMM_32: begin
        fmt     = FMT_I;
        o_b_src = rv64_ctrl_pkg::B_IMM;
        if (funct3 == rv64_isa_pkg::F3_ADD) begin
          o_reg_wen  = 1'b1;
          o_alu_op   = rv64_ctrl_pkg::ALU_ADD;
          o_word_cut = (opcode == rv64_isa_pkg::OP_IMM_32);
        end else if (funct3 == rv64_isa_pkg::F3_SLTU && opcode == rv64_isa_pkg::OP_IMM) begin
          o_reg_wen = 1'b1;
          o_alu_op  = rv64_ctrl_pkg::ALU_SLTU;
        end
      end
      rv64_isa_pkg::OP_REG: begin
        if (funct3 == rv64_isa_pkg::F3_ADD && funct7 == rv64_isa_pkg::F7_BASE) begin
          o_reg_wen = 1'b1;
          o_alu_op  = rv64_ctrl_pkg::ALU_ADD;
        end else if (funct3 == rv64_isa_pkg::F3_ADD && funct7 == rv64_isa_pkg::F7_SUB) begin
          o_reg_wen = 1'b1;
          o_alu_op  = rv64_ctrl_pkg::ALU_SUB;
        end
      end
      rv64_isa_pkg::OP_REG_32: begin
        if (funct3 == rv64_isa_pkg::F3_ADD && funct7 == rv64_isa_pkg::F7_BASE) begin
          o_reg_wen  = 1'b1;
          o_alu_op   = rv64_ctrl_pkg::ALU_ADD;
          o_word_cut = 1'b1;
        end else if (funct3 == rv64_isa_pkg::F3_REMW && funct7 == rv64_isa_pkg::F7_MULDIV) begin
          o_reg_wen  = 1'b1;
          o_alu_op   = rv64_ctrl_pkg::ALU_REMW;
          o_word_cut = 1'b1;
        end
      end
      rv64_isa_pkg::OP_SYSTEM: begin
        fmt    = FMT_I;
        o_halt = (funct3 == rv64_isa_pkg::F3_PRIV) && (funct12 == rv64_isa_pkg::F12_EBREAK);
      end
      default: ;
    endcase
  end

  // Sign-extended immediate per format
  always_comb begin
    case (fmt)
      FMT_I:   o_imm = {{52{i_inst[31]}}, i_inst[31:20]};
      FMT_U:   o_imm = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
      FMT_S:   o_imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      FMT_B:   o_imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      FMT_J:   o_imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      default: o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv64_regfile.sv */
// 32 x 64 register file, two combinational reads, one write, x0 fixed at zero
`default_nettype none

module rv64_regfile (
  input  wire                          i_clk,
  input  wire                          i_arst_n,
  input  wire  rv64_isa_pkg::reg_idx_t i_rs1,
  input  wire  rv64_isa_pkg::reg_idx_t i_rs2,
  input  wire                          i_wen,
  input  wire  rv64_isa_pkg::reg_idx_t i_rd,
  input  wire  rv64_isa_pkg::word_t    i_wdata,
  output rv64_isa_pkg::word_t          o_rdata1,
  output rv64_isa_pkg::word_t          o_rdata2
);

  rv64_isa_pkg::word_t regs [32];

  // Entry 0 is only ever cleared, so it reads as zero
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // Reads see the value from before this cycle's write
  assign o_rdata1 = regs[i_rs1];
  assign o_rdata2 = regs[i_rs2];

endmodule

`default_nettype wire

/* source/rv64_alu.sv */
// ALU with operand select, add/sub/sltu/copy, remw and 32-bit word cut
`default_nettype none

module rv64_alu (
  input  wire  rv64_isa_pkg::word_t    i_pc,
  input  wire  rv64_isa_pkg::word_t    i_rdata1,
  input  wire  rv64_isa_pkg::word_t    i_rdata2,
  input  wire  rv64_isa_pkg::word_t    i_imm,
  input  wire  rv64_ctrl_pkg::a_src_e  i_a_src,
  input  wire  rv64_ctrl_pkg::b_src_e  i_b_src,
  input  wire  rv64_ctrl_pkg::alu_op_e i_alu_op,
  input  wire                          i_word_cut,
  output rv64_isa_pkg::word_t          o_result
);

  rv64_isa_pkg::word_t op_a;
  rv64_isa_pkg::word_t op_b;
  rv64_isa_pkg::word_t raw;
  logic [31:0]         rem_w;

  assign op_a = (i_a_src == rv64_ctrl_pkg::A_PC) ? i_pc : i_rdata1;

  always_comb begin
    case (i_b_src)
      rv64_ctrl_pkg::B_RS2:  op_b = i_rdata2;
      rv64_ctrl_pkg::B_IMM:  op_b = i_imm;
      rv64_ctrl_pkg::B_FOUR: op_b = 64'd4;
      default:               op_b = '0;
    endcase
  end

  // Signed word remainder, zero divisor and overflow per the M extension
  always_comb begin
    if (op_b[31:0] == 32'd0) begin
      rem_w = op_a[31:0];
    end else if (op_a[31:0] == 32'h8000_0000 && op_b[31:0] == 32'hffff_ffff) begin
      rem_w = 32'd0;
    end else begin
      rem_w = $signed(op_a[31:0]) % $signed(op_b[31:0]);
    end
  end

  always_comb begin
    case (i_alu_op)
      rv64_ctrl_pkg::ALU_ADD:    raw = op_a + op_b;
      rv64_ctrl_pkg::ALU_SUB:    raw = op_a - op_b;
      rv64_ctrl_pkg::ALU_SLTU:   raw = {{(rv64_isa_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv64_ctrl_pkg::ALU_COPY_B: raw = op_b;
      rv64_ctrl_pkg::ALU_REMW:   raw = {32'd0, rem_w};
      default:                   raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* source/rv64_pc_unit.sv */
// Program counter register with branch evaluation and next-PC select
`default_nettype none

module rv64_pc_unit (
  input  wire                          i_clk,
  input  wire                          i_arst_n,
  input  wire  rv64_ctrl_pkg::branch_e i_branch,
  input  wire  rv64_isa_pkg::word_t    i_rdata1,
  input  wire  rv64_isa_pkg::word_t    i_rdata2,
  input  wire  rv64_isa_pkg::word_t    i_imm,
  input  wire                          i_halt,
  output rv64_isa_pkg::word_t          o_pc
);

  rv64_isa_pkg::word_t pc_q;
  rv64_isa_pkg::word_t pc_next;
  rv64_isa_pkg::word_t jalr_target;
  logic                taken;

  // The ALU carries the link value, so the jalr target is formed here
  assign jalr_target = (i_rdata1 + i_imm) & ~64'd1;

  always_comb begin
    case (i_branch)
      rv64_ctrl_pkg::BR_JAL: taken = 1'b1;
      rv64_ctrl_pkg::BR_EQ:  taken = (i_rdata1 == i_rdata2);
      rv64_ctrl_pkg::BR_NE:  taken = (i_rdata1 != i_rdata2);
      rv64_ctrl_pkg::BR_LTU: taken = (i_rdata1 < i_rdata2);
      rv64_ctrl_pkg::BR_GEU: taken = (i_rdata1 >= i_rdata2);
      default:               taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_halt) begin
      pc_next = pc_q;
    end else if (i_branch == rv64_ctrl_pkg::BR_JALR) begin
      pc_next = jalr_target;
    end else if (taken) begin
      pc_next = pc_q + i_imm;
    end else begin
      pc_next = pc_q + 64'd4;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= rv64_isa_pkg::RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

/* source/rv64_lsu.sv */
// Load/store unit forming data memory requests and extending load data
`default_nettype none

module rv64_lsu (
  input  wire  rv64_ctrl_pkg::mem_op_e i_mem_op,
  input  wire                          i_mem_wen,
  input  wire  rv64_isa_pkg::word_t    i_addr,
  input  wire  rv64_isa_pkg::word_t    i_rdata2,
  input  wire  rv64_isa_pkg::word_t    i_dmem_rdata,
  output rv64_isa_pkg::word_t          o_dmem_addr,
  output rv64_isa_pkg::word_t          o_dmem_wdata,
  output logic                         o_dmem_wen,
  output logic                         o_dmem_double,
  output rv64_isa_pkg::word_t          o_load_data
);

  assign o_dmem_addr   = i_addr;
  assign o_dmem_wen    = i_mem_wen && (i_mem_op != rv64_ctrl_pkg::MEM_NONE);
  assign o_dmem_double = (i_mem_op == rv64_ctrl_pkg::MEM_DOUBLE);

  // Word stores sit in the low half
  always_comb begin
    case (i_mem_op)
      rv64_ctrl_pkg::MEM_WORD:   o_dmem_wdata = {32'd0, i_rdata2[31:0]};
      rv64_ctrl_pkg::MEM_DOUBLE: o_dmem_wdata = i_rdata2;
      default:                   o_dmem_wdata = '0;
    endcase
  end

  always_comb begin
    case (i_mem_op)
      rv64_ctrl_pkg::MEM_WORD:   o_load_data = {{32{i_dmem_rdata[31]}}, i_dmem_rdata[31:0]};
      rv64_ctrl_pkg::MEM_DOUBLE: o_load_data = i_dmem_rdata;
      default:                   o_load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/rv64_core.sv */
// Single-cycle RV64I core top connecting decode, registers, ALU, PC and LSU
`default_nettype none

module rv64_core (
  input  wire                          i_clk,
  input  wire                          i_arst_n,
  input  wire  rv64_isa_pkg::inst_t    i_inst,
  output rv64_isa_pkg::word_t          o_pc,
  output rv64_isa_pkg::word_t          o_dmem_addr,
  output rv64_isa_pkg::word_t          o_dmem_wdata,
  output logic                         o_dmem_wen,
  output logic                         o_dmem_double,
  input  wire  rv64_isa_pkg::word_t    i_dmem_rdata,
  output logic                         o_wb_en,
  output rv64_isa_pkg::reg_idx_t       o_wb_rd,
  output rv64_isa_pkg::word_t          o_wb_data,
  output logic                         o_halt
);

  rv64_isa_pkg::reg_idx_t  rs1;
  rv64_isa_pkg::reg_idx_t  rs2;
  rv64_isa_pkg::word_t     imm;
  rv64_isa_pkg::word_t     rdata1;
  rv64_isa_pkg::word_t     rdata2;
  rv64_isa_pkg::word_t     alu_result;
  rv64_isa_pkg::word_t     load_data;
  rv64_ctrl_pkg::a_src_e   a_src;
  rv64_ctrl_pkg::b_src_e   b_src;
  rv64_ctrl_pkg::alu_op_e  alu_op;
  rv64_ctrl_pkg::branch_e  branch;
  rv64_ctrl_pkg::mem_op_e  mem_op;
  logic                    word_cut;
  logic                    mem_wen;
  logic                    mem_to_reg;

  rv64_idu u_idu (
    .i_inst       (i_inst),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_rd         (o_wb_rd),
    .o_imm        (imm),
    .o_reg_wen    (o_wb_en),
    .o_a_src      (a_src),
    .o_b_src      (b_src),
    .o_alu_op     (alu_op),
    .o_word_cut   (word_cut),
    .o_branch     (branch),
    .o_mem_op     (mem_op),
    .o_mem_wen    (mem_wen),
    .o_mem_to_reg (mem_to_reg),
    .o_halt       (o_halt)
  );

  rv64_regfile u_regfile (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_wen    (o_wb_en),
    .i_rd     (o_wb_rd),
    .i_wdata  (o_wb_data),
    .o_rdata1 (rdata1),
    .o_rdata2 (rdata2)
  );

  rv64_alu u_alu (
    .i_pc       (o_pc),
    .i_rdata1   (rdata1),
    .i_rdata2   (rdata2),
    .i_imm      (imm),
    .i_a_src    (a_src),
    .i_b_src    (b_src),
    .i_alu_op   (alu_op),
    .i_word_cut (word_cut),
    .o_result   (alu_result)
  );

  rv64_pc_unit u_pc_unit (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_branch (branch),
    .i_rdata1 (rdata1),
    .i_rdata2 (rdata2),
    .i_imm    (imm),
    .i_halt   (o_halt),
    .o_pc     (o_pc)
  );

  rv64_lsu u_lsu (
    .i_mem_op      (mem_op),
    .i_mem_wen     (mem_wen),
    .i_addr        (alu_result),
    .i_rdata2      (rdata2),
    .i_dmem_rdata  (i_dmem_rdata),
    .o_dmem_addr   (o_dmem_addr),
    .o_dmem_wdata  (o_dmem_wdata),
    .o_dmem_wen    (o_dmem_wen),
    .o_dmem_double (o_dmem_double),
    .o_load_data   (load_data)
  );

  // Loads write back memory data, everything else the ALU result
  assign o_wb_data = mem_to_reg ? load_data : alu_result;

endmodule

`default_nettype wire

/* tests/rv64_core_tb.sv */
// Testbench for the single-cycle RV64 core, replaying per-cycle vectors from a file
`default_nettype none

module rv64_core_tb;

  logic                   i_clk;
  logic                   i_arst_n;
  rv64_isa_pkg::inst_t    i_inst;
  rv64_isa_pkg::word_t    i_dmem_rdata;
  rv64_isa_pkg::word_t    o_pc;
  rv64_isa_pkg::word_t    o_dmem_addr;
  rv64_isa_pkg::word_t    o_dmem_wdata;
  logic                   o_dmem_wen;
  logic                   o_dmem_double;
  logic                   o_wb_en;
  rv64_isa_pkg::reg_idx_t o_wb_rd;
  rv64_isa_pkg::word_t    o_wb_data;
  logic                   o_halt;

  // One entry per vector line
  int                     vec_id      [$];
  rv64_isa_pkg::inst_t    vec_inst    [$];
  rv64_isa_pkg::word_t    vec_ldata   [$];
  rv64_isa_pkg::word_t    vec_pc      [$];
  logic                   vec_wb_en   [$];
  rv64_isa_pkg::reg_idx_t vec_rd      [$];
  rv64_isa_pkg::word_t    vec_wb_data [$];
  logic                   vec_st_en   [$];
  rv64_isa_pkg::word_t    vec_st_addr [$];
  rv64_isa_pkg::word_t    vec_st_data [$];
  logic                   vec_halt    [$];

  logic loaded       = 1'b0;
  int   cur_id       = 0;
  int   step_idx     = 0;
  int   checks       = 0;
  int   errors       = 0;
  int   test_errs    = 0;
  int   test_steps   = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;

  rv64_core u_dut (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_inst        (i_inst),
    .o_pc          (o_pc),
    .o_dmem_addr   (o_dmem_addr),
    .o_dmem_wdata  (o_dmem_wdata),
    .o_dmem_wen    (o_dmem_wen),
    .o_dmem_double (o_dmem_double),
    .i_dmem_rdata  (i_dmem_rdata),
    .o_wb_en       (o_wb_en),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data),
    .o_halt        (o_halt)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic check_word(input string name, input rv64_isa_pkg::word_t got,
                            input rv64_isa_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h (test %0d, step %0d)",
               name, got, exp, cur_id, step_idx);
    end
  endtask

  task automatic check_reg(input string name, input rv64_isa_pkg::reg_idx_t got,
                           input rv64_isa_pkg::reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h (test %0d, step %0d)",
               name, got, exp, cur_id, step_idx);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("mismatch %s: got 0x%h, expected 0x%h (test %0d, step %0d)",
               name, got, exp, cur_id, step_idx);
    end
  endtask

  // sd carries funct3 011, sw carries 010
  function automatic logic store_is_double(input rv64_isa_pkg::inst_t inst);
    return inst[14:12] == 3'b011;
  endfunction

  task automatic read_vectors(output bit ok);
    int                     fd;
    int                     cnt;
    string                  line;
    int                     id;
    rv64_isa_pkg::inst_t    inst;
    rv64_isa_pkg::word_t    ldata;
    rv64_isa_pkg::word_t    pc;
    logic                   wb_en;
    rv64_isa_pkg::reg_idx_t rd;
    rv64_isa_pkg::word_t    wb_data;
    logic                   st_en;
    rv64_isa_pkg::word_t    st_addr;
    rv64_isa_pkg::word_t    st_data;
    logic                   halt;
    ok = 1'b1;
    fd = $fopen("tests/rv64_core_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tests/rv64_core_stimulus.txt");
      ok = 1'b0;
    end else begin
      while (ok && $fgets(line, fd) != 0) begin
        // Blank and comment lines carry no vector
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", id, inst, ldata, pc,
                        wb_en, rd, wb_data, st_en, st_addr, st_data, halt);
          if (cnt != 11) begin
            $display("stimulus line has %0d fields instead of 11: %s", cnt, line);
            ok = 1'b0;
          end else begin
            vec_id.push_back(id);
            vec_inst.push_back(inst);
            vec_ldata.push_back(ldata);
            vec_pc.push_back(pc);
            vec_wb_en.push_back(wb_en);
            vec_rd.push_back(rd);
            vec_wb_data.push_back(wb_data);
            vec_st_en.push_back(st_en);
            vec_st_addr.push_back(st_addr);
            vec_st_data.push_back(st_data);
            vec_halt.push_back(halt);
          end
        end
      end
      $fclose(fd);
      if (ok && vec_id.size() == 0) begin
        $display("the stimulus file holds no vectors");
        ok = 1'b0;
      end
    end
  endtask

  task automatic report_test(input int id);
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %0d finished: %0d steps, %0d errors", id, test_steps, test_errs);
    test_errs  = 0;
    test_steps = 0;
  endtask

  // Results sampled a quarter period after the falling edge
  task automatic apply_and_check(input int k);
    cur_id   = vec_id[k];
    step_idx = test_steps;
    test_steps++;
    check_word("o_pc", o_pc, vec_pc[k]);
    i_inst       = vec_inst[k];
    i_dmem_rdata = vec_ldata[k];
    #5;
    check_bit("o_wb_en", o_wb_en, vec_wb_en[k]);
    if (vec_wb_en[k]) begin
      check_reg("o_wb_rd", o_wb_rd, vec_rd[k]);
      check_word("o_wb_data", o_wb_data, vec_wb_data[k]);
    end
    check_bit("o_dmem_wen", o_dmem_wen, vec_st_en[k]);
    if (vec_st_en[k]) begin
      check_word("o_dmem_addr", o_dmem_addr, vec_st_addr[k]);
      check_word("o_dmem_wdata", o_dmem_wdata, vec_st_data[k]);
      check_bit("o_dmem_double", o_dmem_double, store_is_double(vec_inst[k]));
    end
    check_bit("o_halt", o_halt, vec_halt[k]);
  endtask

  initial begin
    bit ok;
    i_arst_n     = 1'b0;
    i_inst       = 32'h0000_0013;
    i_dmem_rdata = '0;
    read_vectors(ok);
    if (!ok) begin
      $display("FAIL: see errors above");
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge i_clk);
      @(negedge i_clk);
      i_arst_n = 1'b1;
      for (int k = 0; k < vec_id.size(); k++) begin
        if (k > 0) begin
          @(negedge i_clk);
          if (vec_id[k] != vec_id[k-1]) begin
            report_test(vec_id[k-1]);
          end
        end
        apply_and_check(k);
      end
      report_test(vec_id[vec_id.size()-1]);
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
    end
    $finish;
  end

  // Watchdog scaled by the vector count
  initial begin
    wait (loaded);
    #((vec_id.size() + 10) * 40);
    $display("timeout: the vectors did not complete within the time limit");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* rv64_core.f */
source/rv64_isa_pkg.sv
source/rv64_ctrl_pkg.sv
source/rv64_idu.sv
source/rv64_regfile.sv
source/rv64_alu.sv
source/rv64_pc_unit.sv
source/rv64_lsu.sv
source/rv64_core.sv
tests/rv64_core_tb.sv

/* Makefile */
# Verilator build and run for the rv64_core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module rv64_core_tb -Mdir obj_dir -f rv64_core.f
	./obj_dir/Vrv64_core_tb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/rv64_core_stimulus.txt */
# id inst load_data pc wb_en wb_rd wb_data st_en st_addr st_data halt
# Hex except id; wb_rd/wb_data and st_addr/st_data are ignored when their enable is 0
1 123450b7 0 80000000 1 01 12345000 0 0 0 0
1 00001117 0 80000004 1 02 80001004 0 0 0 0
1 800001b7 0 80000008 1 03 ffffffff80000000 0 0 0 0
1 67808213 0 8000000c 1 04 12345678 0 0 0 0
1 fff00293 0 80000010 1 05 ffffffffffffffff 0 0 0 0
1 00123313 0 80000014 1 06 0 0 0 0 0
1 00103393 0 80000018 1 07 1 0 0 0 0
1 fff23413 0 8000001c 1 08 1 0 0 0 0
1 005204b3 0 80000020 1 09 12345677 0 0 0 0
1 40408533 0 80000024 1 0a fffffffffffff988 0 0 0 0
1 00520013 0 80000028 1 00 1234567d 0 0 0 0
1 004005b3 0 8000002c 1 0b 12345678 0 0 0 0
2 fff1861b 0 80000030 1 0c 7fffffff 0 0 0 0
2 007606bb 0 80000034 1 0d ffffffff80000000 0 0 0 0
2 ff900793 0 80000038 1 0f fffffffffffffff9 0 0 0 0
2 02f5673b 0 8000003c 1 0e fffffffffffffffc 0 0 0 0
2 02f2683b 0 80000040 1 10 5 0 0 0 0
2 0206e8bb 0 80000044 1 11 ffffffff80000000 0 0 0 0
2 0256e93b 0 80000048 1 12 0 0 0 0 0
3 0080a983 deadbeef87654321 8000004c 1 13 ffffffff87654321 0 0 0 0
3 ffc0aa03 1111111122334455 80000050 1 14 22334455 0 0 0 0
3 0100ba83 deadbeef87654321 80000054 1 15 deadbeef87654321 0 0 0 0
3 0130a623 0 80000058 0 00 0 1 1234500c 87654321 0
3 ff50bc23 0 8000005c 0 00 0 1 12344ff8 deadbeef87654321 0
4 01000b6f 0 80000060 1 16 80000064 0 0 0 0
4 009b0be7 0 80000070 1 17 80000074 0 0 0 0
4 00b20663 0 8000006c 0 00 0 0 0 0 0
4 00120663 0 80000078 0 00 0 0 0 0 0
4 feb21ce3 0 8000007c 0 00 0 0 0 0 0
4 00121663 0 80000080 0 00 0 0 0 0 0
4 0053e463 0 8000008c 0 00 0 0 0 0 0
4 0072e463 0 80000094 0 00 0 0 0 0 0
4 0072f463 0 80000098 0 00 0 0 0 0 0
4 0053f463 0 800000a0 0 00 0 0 0 0 0
5 00100073 0 800000a4 0 00 0 0 0 0 1
5 00100073 0 800000a4 0 00 0 0 0 0 1
5 00100073 0 800000a4 0 00 0 0 0 0 1
5 00100073 0 800000a4 0 00 0 0 0 0 1
